// File: Makefile
# Verilator build and run of the fetch unit testbench.
VERILATOR ?= verilator
TOP       ?= fetchUnitTb
FLIST     ?= fetchUnit.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= ERRORS FOUND
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, scan $(LOG) for failure"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: fetchUnit.f
hw/fetchPkg.sv
hw/preDecode.sv
hw/ctiQueue.sv
hw/fetchStage2.sv
hw/fetchBundleReg.sv
hw/fetchUnit.sv
verif/fetchUnitTb.sv

// File: hw/ctiQueue.sv
// Circular control-transfer queue; allocates tags, records resolution and retires BTB updates.
`default_nettype none

module ctiQueue import fetchPkg::*; #(
  parameter  int CtiDepth = 16,
  localparam int TagW     = $clog2(CtiDepth)
) (
  input  logic                                clk,
  input  logic                                reset_i,
  input  logic                                flush_i,
  input  logic                                allocEn_i,
  input  logic [FETCH_WIDTH-1:0]              allocMask_i,
  input  logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0] slotPc_i,
  input  logic [FETCH_WIDTH-1:0][1:0]         slotCtrlType_i,
  input  logic                                resolveValid_i,
  input  logic [TagW-1:0]                     resolveTag_i,
  input  logic [PC_WIDTH-1:0]                 resolveTarget_i,
  input  logic                                resolveTaken_i,
  input  logic                                recoverEx_i,
  input  logic                                commitValid_i,
  output logic [FETCH_WIDTH-1:0][TagW-1:0]    slotTag_o,
  output logic                                queueFull_o,
  output logic [PC_WIDTH-1:0]                 updatePc_o,
  output logic [PC_WIDTH-1:0]                 updateTarget_o,
  output logic [1:0]                          updateCtrlType_o,
  output logic                                updateDir_o,
  output logic                                updateEn_o
);

  logic [PC_WIDTH-1:0] pcMem     [CtiDepth];
  logic [PC_WIDTH-1:0] targetMem [CtiDepth];
  logic [1:0]          typeMem   [CtiDepth];
  logic                dirMem    [CtiDepth];

  logic [TagW-1:0] head;
  logic [TagW-1:0] tail;
  logic [TagW:0]   count;
  logic [TagW-1:0] allocNum;
  logic [TagW-1:0] keepOff;
  logic [TagW:0]   keepCount;
  logic [TagW:0]   allocAdd;
  logic [TagW:0]   commitDec;
  logic            doAlloc;

  // masked slots take consecutive tags; others see the next free one.
  always_comb begin
    logic [TagW-1:0] nextTag;
    nextTag = tail;
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      slotTag_o[k] = nextTag;
      nextTag      = nextTag + TagW'(allocMask_i[k]);
    end
    allocNum = nextTag - tail;
  end

  assign doAlloc     = allocEn_i & ~recoverEx_i & ~flush_i;
  assign keepOff     = resolveTag_i - head;
  assign keepCount   = {1'b0, keepOff} + 1'b1; // entries up to the mispredicted one survive.
  assign allocAdd    = allocEn_i ? {1'b0, allocNum} : '0;
  assign commitDec   = {{TagW{1'b0}}, commitValid_i};
  assign queueFull_o = count > (TagW+1)'(CtiDepth - FETCH_WIDTH);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      head        <= '0;
      tail        <= '0;
      count       <= '0;
      updateEn_o  <= 1'b0;
    end else begin
      updateEn_o <= commitValid_i & ~flush_i;
      if (flush_i) begin
        head  <= tail;
        count <= '0;
      end else begin
        if (commitValid_i) head <= head + 1'b1;
        if (recoverEx_i) begin
          tail  <= resolveTag_i + 1'b1;
          count <= keepCount - commitDec;
        end else begin
          if (allocEn_i) tail <= tail + allocNum;
          count <= count + allocAdd - commitDec;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (doAlloc) begin
      for (int k = 0; k < FETCH_WIDTH; k++) begin
        if (allocMask_i[k]) begin
          pcMem[slotTag_o[k]]   <= slotPc_i[k];
          typeMem[slotTag_o[k]] <= slotCtrlType_i[k];
        end
      end
    end
    if (resolveValid_i) begin
      targetMem[resolveTag_i] <= resolveTarget_i;
      dirMem[resolveTag_i]    <= resolveTaken_i;
    end
    if (commitValid_i) begin
      updatePc_o       <= pcMem[head];
      updateTarget_o   <= targetMem[head];
      updateCtrlType_o <= typeMem[head];
      updateDir_o      <= dirMem[head];
    end
  end

  // the stage must hold fetch back before the queue can overflow.
  allocNotFull: assert property (@(posedge clk) disable iff (reset_i)
    allocEn_i |-> !queueFull_o);

  commitNotEmpty: assert property (@(posedge clk) disable iff (reset_i)
    commitValid_i |-> count != '0);

endmodule

`default_nettype wire

// File: hw/fetchBundleReg.sv
// One-entry valid/ready register that holds the filtered fetch bundle for decode.
`default_nettype none

module fetchBundleReg import fetchPkg::*; #(
  parameter  int CtiDepth = 16,
  localparam int TagW     = $clog2(CtiDepth)
) (
  input  logic                                  clk,
  input  logic                                  reset_i,
  input  logic                                  flush_i,
  input  logic                                  inValid_i,
  output logic                                  inReady_o,
  input  logic [FETCH_WIDTH-1:0]                slotValid_i,
  input  logic [FETCH_WIDTH-1:0][INST_WIDTH-1:0] slotInst_i,
  input  logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0]  slotPc_i,
  input  logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0]  slotTarget_i,
  input  logic [FETCH_WIDTH-1:0][TagW-1:0]      slotTag_i,
  input  logic [FETCH_WIDTH-1:0]                slotPred_i,
  output logic                                  bundleValid_o,
  input  logic                                  outReady_i,
  output logic [FETCH_WIDTH-1:0]                slotValid_o,
  output logic [FETCH_WIDTH-1:0][INST_WIDTH-1:0] slotInst_o,
  output logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0]  slotPc_o,
  output logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0]  slotTarget_o,
  output logic [FETCH_WIDTH-1:0][TagW-1:0]      slotTag_o,
  output logic [FETCH_WIDTH-1:0]                slotPred_o
);

  logic load;

  assign inReady_o = ~bundleValid_o | outReady_i; // empty, or the held bundle leaves now.
  assign load      = inValid_i & inReady_o;

  always_ff @(posedge clk) begin
    if (reset_i || flush_i) begin
      bundleValid_o <= 1'b0;
    end else if (inReady_o) begin
      bundleValid_o <= inValid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      slotValid_o  <= slotValid_i;
      slotInst_o   <= slotInst_i;
      slotPc_o     <= slotPc_i;
      slotTarget_o <= slotTarget_i;
      slotTag_o    <= slotTag_i;
      slotPred_o   <= slotPred_i;
    end
  end

  // decode may sample the bundle on any cycle while it stalls.
  holdOnStall: assert property (@(posedge clk) disable iff (reset_i)
    bundleValid_o && !outReady_i && !flush_i |=> bundleValid_o && $stable(slotValid_o)
      && $stable(slotInst_o) && $stable(slotPc_o) && $stable(slotTarget_o)
      && $stable(slotTag_o) && $stable(slotPred_o));

endmodule

`default_nettype wire

// File: hw/fetchPkg.sv
// Shared widths, opcodes, control-type codes and instruction formats; imported by fetch RTL.
`default_nettype none

package fetchPkg;

  localparam int PC_WIDTH    = 32;
  localparam int INST_WIDTH  = 32;
  localparam int FETCH_WIDTH = 4;
  localparam int SLOT_W      = $clog2(FETCH_WIDTH); // index of one slot in a bundle.

  // control-transfer types, as stored in the queue and sent to the BTB.
  localparam logic [1:0] CTRL_RETURN = 2'd0;
  localparam logic [1:0] CTRL_CALL   = 2'd1;
  localparam logic [1:0] CTRL_JUMP   = 2'd2;
  localparam logic [1:0] CTRL_COND   = 2'd3;

  localparam logic [5:0] OP_J   = 6'h02;
  localparam logic [5:0] OP_JAL = 6'h03;
  localparam logic [5:0] OP_BEQ = 6'h04;
  localparam logic [5:0] OP_BNE = 6'h05;
  localparam logic [5:0] OP_JR  = 6'h08; // register-indirect, treated as a return.

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] offset; // word offset from the next pc.
  } brFmt_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] index; // word index within the current 256 MB region.
  } jmpFmt_t;

  typedef union packed {
    brFmt_t  br;
    jmpFmt_t jmp;
  } instWord_u;

endpackage

`default_nettype wire

// File: hw/fetchStage2.sv
// Second fetch stage; predecodes a 4-wide bundle, checks BTB predictions and tags control slots.
`default_nettype none

module fetchStage2 import fetchPkg::*; #(
  parameter  int CtiDepth = 16,
  localparam int TagW     = $clog2(CtiDepth)
) (
  input  logic                                  clk,
  input  logic                                  reset_i,
  input  logic                                  flush_i,
  input  logic                                  fs1Valid_i,
  input  logic [PC_WIDTH-1:0]                   pc_i,
  input  logic [FETCH_WIDTH-1:0][INST_WIDTH-1:0] bundle_i,
  input  logic [FETCH_WIDTH-1:0]                btbHit_i,
  input  logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0]  btbTarget_i,
  input  logic [FETCH_WIDTH-1:0]                prediction_i,
  input  logic [PC_WIDTH-1:0]                   rasTop_i,
  input  logic                                  outReady_i,
  input  logic                                  resolveValid_i,
  input  logic [TagW-1:0]                       resolveTag_i,
  input  logic [PC_WIDTH-1:0]                   resolveTarget_i,
  input  logic                                  resolveTaken_i,
  input  logic                                  recoverEx_i,
  input  logic                                  commitValid_i,
  output logic                                  fs2Ready_o,
  output logic                                  flagRecover_o,
  output logic                                  flagReturn_o,
  output logic                                  flagCall_o,
  output logic [PC_WIDTH-1:0]                   redirectTarget_o,
  output logic [PC_WIDTH-1:0]                   callPc_o,
  output logic [FETCH_WIDTH-1:0]                slotValid_o,
  output logic [FETCH_WIDTH-1:0][INST_WIDTH-1:0] slotInst_o,
  output logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0]  slotPc_o,
  output logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0]  slotTarget_o,
  output logic [FETCH_WIDTH-1:0][TagW-1:0]      slotTag_o,
  output logic [FETCH_WIDTH-1:0]                slotPred_o,
  output logic [PC_WIDTH-1:0]                   updatePc_o,
  output logic [PC_WIDTH-1:0]                   updateTarget_o,
  output logic [1:0]                            updateCtrlType_o,
  output logic                                  updateDir_o,
  output logic                                  updateEn_o
);

  logic [FETCH_WIDTH-1:0]               isCtrl;
  logic [FETCH_WIDTH-1:0][1:0]          ctrlType;
  logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0] decTarget;
  logic [FETCH_WIDTH-1:0]               redirect;
  logic [SLOT_W-1:0]                    firstIdx;
  logic                                 anyRedirect;
  logic                                 btbMiss;
  logic                                 accept;
  logic                                 queueFull;

  for (genvar k = 0; k < FETCH_WIDTH; k++) begin : gSlot
    assign slotPc_o[k] = pc_i + PC_WIDTH'(4 * k);

    preDecode uPreDecode (
      .pc_i      (slotPc_o[k]),
      .inst_i    (bundle_i[k]),
      .isCtrl_o  (isCtrl[k]),
      .ctrlType_o(ctrlType[k]),
      .target_o  (decTarget[k])
    );

    // not-taken conditionals let fetch continue past them.
    assign redirect[k] = isCtrl[k] & (prediction_i[k] | (ctrlType[k] != CTRL_COND));
  end

  assign slotInst_o = bundle_i;
  assign slotPred_o = prediction_i;

  // keep slots up to and including the first redirecting one.
  always_comb begin
    logic found;
    found    = 1'b0;
    firstIdx = '0;
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      slotValid_o[k] = !found;
      if (!found && redirect[k]) begin
        found    = 1'b1;
        firstIdx = SLOT_W'(k);
      end
    end
    anyRedirect = found;
  end

  assign btbMiss = anyRedirect & ~btbHit_i[firstIdx];

  always_comb begin
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      slotTarget_o[k] = (ctrlType[k] == CTRL_RETURN) ? btbTarget_i[k] : decTarget[k];
    end
    if (btbMiss && ctrlType[firstIdx] == CTRL_RETURN) begin
      slotTarget_o[firstIdx] = rasTop_i; // no BTB entry, so fall back on the RAS.
    end
  end

  assign fs2Ready_o       = outReady_i & ~queueFull;
  assign accept           = fs1Valid_i & fs2Ready_o;
  assign flagRecover_o    = accept & btbMiss;
  assign flagReturn_o     = btbMiss & (ctrlType[firstIdx] == CTRL_RETURN);
  assign flagCall_o       = btbMiss & (ctrlType[firstIdx] == CTRL_CALL);
  assign redirectTarget_o = slotTarget_o[firstIdx];
  assign callPc_o         = slotPc_o[firstIdx];

  ctiQueue #(.CtiDepth(CtiDepth)) uCtiQueue (
    .clk             (clk),
    .reset_i         (reset_i),
    .flush_i         (flush_i),
    .allocEn_i       (accept),
    .allocMask_i     (slotValid_o & isCtrl),
    .slotPc_i        (slotPc_o),
    .slotCtrlType_i  (ctrlType),
    .resolveValid_i  (resolveValid_i),
    .resolveTag_i    (resolveTag_i),
    .resolveTarget_i (resolveTarget_i),
    .resolveTaken_i  (resolveTaken_i),
    .recoverEx_i     (recoverEx_i),
    .commitValid_i   (commitValid_i),
    .slotTag_o       (slotTag_o),
    .queueFull_o     (queueFull),
    .updatePc_o      (updatePc_o),
    .updateTarget_o  (updateTarget_o),
    .updateCtrlType_o(updateCtrlType_o),
    .updateDir_o     (updateDir_o),
    .updateEn_o      (updateEn_o)
  );

endmodule

`default_nettype wire

// File: hw/fetchUnit.sv
// Top of the fetch back end; joins stage 2 to the decode-side bundle register.
`default_nettype none

module fetchUnit import fetchPkg::*; #(
  parameter  int CtiDepth = 16,
  localparam int TagW     = $clog2(CtiDepth)
) (
  input  logic                                  clk,
  input  logic                                  reset_i,
  input  logic                                  flush_i,
  input  logic                                  fs1Valid_i,
  input  logic [PC_WIDTH-1:0]                   pc_i,
  input  logic [FETCH_WIDTH-1:0][INST_WIDTH-1:0] bundle_i,
  input  logic [FETCH_WIDTH-1:0]                btbHit_i,
  input  logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0]  btbTarget_i,
  input  logic [FETCH_WIDTH-1:0]                prediction_i,
  input  logic [PC_WIDTH-1:0]                   rasTop_i,
  input  logic                                  decodeReady_i,
  input  logic                                  resolveValid_i,
  input  logic [TagW-1:0]                       resolveTag_i,
  input  logic [PC_WIDTH-1:0]                   resolveTarget_i,
  input  logic                                  resolveTaken_i,
  input  logic                                  recoverEx_i,
  input  logic                                  commitValid_i,
  output logic                                  fs2Ready_o,
  output logic                                  flagRecover_o,
  output logic                                  flagReturn_o,
  output logic                                  flagCall_o,
  output logic [PC_WIDTH-1:0]                   redirectTarget_o,
  output logic [PC_WIDTH-1:0]                   callPc_o,
  output logic [PC_WIDTH-1:0]                   updatePc_o,
  output logic [PC_WIDTH-1:0]                   updateTarget_o,
  output logic [1:0]                            updateCtrlType_o,
  output logic                                  updateDir_o,
  output logic                                  updateEn_o,
  output logic                                  bundleValid_o,
  output logic [FETCH_WIDTH-1:0]                slotValid_o,
  output logic [FETCH_WIDTH-1:0][INST_WIDTH-1:0] slotInst_o,
  output logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0]  slotPc_o,
  output logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0]  slotTarget_o,
  output logic [FETCH_WIDTH-1:0][TagW-1:0]      slotTag_o,
  output logic [FETCH_WIDTH-1:0]                slotPred_o
);

  logic                                  regReady;
  logic                                  acceptValid;
  logic [FETCH_WIDTH-1:0]                fs2Valid;
  logic [FETCH_WIDTH-1:0][INST_WIDTH-1:0] fs2Inst;
  logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0]  fs2Pc;
  logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0]  fs2Target;
  logic [FETCH_WIDTH-1:0][TagW-1:0]      fs2Tag;
  logic [FETCH_WIDTH-1:0]                fs2Pred;

  assign acceptValid = fs1Valid_i & fs2Ready_o; // only bundles that got queue tags move on.

  fetchStage2 #(.CtiDepth(CtiDepth)) uFetchStage2 (
    .clk(clk), .reset_i(reset_i), .flush_i(flush_i),
    .fs1Valid_i(fs1Valid_i), .pc_i(pc_i), .bundle_i(bundle_i),
    .btbHit_i(btbHit_i), .btbTarget_i(btbTarget_i), .prediction_i(prediction_i),
    .rasTop_i(rasTop_i), .outReady_i(regReady),
    .resolveValid_i(resolveValid_i), .resolveTag_i(resolveTag_i),
    .resolveTarget_i(resolveTarget_i), .resolveTaken_i(resolveTaken_i),
    .recoverEx_i(recoverEx_i), .commitValid_i(commitValid_i),
    .fs2Ready_o(fs2Ready_o), .flagRecover_o(flagRecover_o),
    .flagReturn_o(flagReturn_o), .flagCall_o(flagCall_o),
    .redirectTarget_o(redirectTarget_o), .callPc_o(callPc_o),
    .slotValid_o(fs2Valid), .slotInst_o(fs2Inst), .slotPc_o(fs2Pc),
    .slotTarget_o(fs2Target), .slotTag_o(fs2Tag), .slotPred_o(fs2Pred),
    .updatePc_o(updatePc_o), .updateTarget_o(updateTarget_o),
    .updateCtrlType_o(updateCtrlType_o), .updateDir_o(updateDir_o),
    .updateEn_o(updateEn_o)
  );

  fetchBundleReg #(.CtiDepth(CtiDepth)) uFetchBundleReg (
    .clk(clk), .reset_i(reset_i), .flush_i(flush_i),
    .inValid_i(acceptValid), .inReady_o(regReady),
    .slotValid_i(fs2Valid), .slotInst_i(fs2Inst), .slotPc_i(fs2Pc),
    .slotTarget_i(fs2Target), .slotTag_i(fs2Tag), .slotPred_i(fs2Pred),
    .bundleValid_o(bundleValid_o), .outReady_i(decodeReady_i),
    .slotValid_o(slotValid_o), .slotInst_o(slotInst_o), .slotPc_o(slotPc_o),
    .slotTarget_o(slotTarget_o), .slotTag_o(slotTag_o), .slotPred_o(slotPred_o)
  );

endmodule

`default_nettype wire

// File: hw/preDecode.sv
// Single-slot predecoder; classifies one instruction and computes its static target.
`default_nettype none

module preDecode import fetchPkg::*; (
  input  logic [PC_WIDTH-1:0] pc_i,
  input  instWord_u           inst_i,
  output logic                isCtrl_o,
  output logic [1:0]          ctrlType_o,
  output logic [PC_WIDTH-1:0] target_o
);

  logic [PC_WIDTH-1:0] seqPc;
  logic [PC_WIDTH-1:0] brTarget;
  logic [PC_WIDTH-1:0] jmpTarget;

  assign seqPc     = pc_i + PC_WIDTH'(4);
  assign brTarget  = seqPc + {{(PC_WIDTH-18){inst_i.br.offset[15]}}, inst_i.br.offset, 2'b00};
  assign jmpTarget = {pc_i[PC_WIDTH-1 -: 4], inst_i.jmp.index, 2'b00};

  // a return's real target is supplied later from the BTB or the RAS.
  always_comb begin
    isCtrl_o   = 1'b1;
    ctrlType_o = CTRL_COND;
    target_o   = seqPc;
    case (inst_i.jmp.opcode)
      OP_BEQ, OP_BNE: begin
        target_o = brTarget;
      end
      OP_J: begin
        ctrlType_o = CTRL_JUMP;
        target_o   = jmpTarget;
      end
      OP_JAL: begin
        ctrlType_o = CTRL_CALL;
        target_o   = jmpTarget;
      end
      OP_JR: begin
        ctrlType_o = CTRL_RETURN;
      end
      default: begin
        isCtrl_o = 1'b0; // plain instruction, falls through.
      end
    endcase
  end

endmodule

`default_nettype wire

// File: verif/fetchUnitTb.sv
// Testbench for fetchUnit; random and directed bundles checked against a predecode and queue model.
`default_nettype none

module fetchUnitTb import fetchPkg::*; ();

  localparam int CtiDepth = 16;
  localparam int TagW     = $clog2(CtiDepth);
  localparam int N_RAND   = 40;
  localparam int N_HIT    = 10;
  localparam int LIMIT    = 3 * (10 + N_RAND * 8 + (N_HIT + 2) * 8 + 90 + 90 + 70) / 2;

  logic clk = 1'b0;
  logic reset_i, flush_i, fs1Valid_i, decodeReady_i;
  logic [PC_WIDTH-1:0] pc_i, rasTop_i, resolveTarget_i;
  logic [FETCH_WIDTH-1:0][INST_WIDTH-1:0] bundle_i;
  logic [FETCH_WIDTH-1:0] btbHit_i, prediction_i;
  logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0] btbTarget_i;
  logic resolveValid_i, resolveTaken_i, recoverEx_i, commitValid_i;
  logic [TagW-1:0] resolveTag_i;
  logic fs2Ready_o, flagRecover_o, flagReturn_o, flagCall_o, updateDir_o, updateEn_o;
  logic [PC_WIDTH-1:0] redirectTarget_o, callPc_o, updatePc_o, updateTarget_o;
  logic [1:0] updateCtrlType_o;
  logic bundleValid_o;
  logic [FETCH_WIDTH-1:0] slotValid_o, slotPred_o;
  logic [FETCH_WIDTH-1:0][INST_WIDTH-1:0] slotInst_o;
  logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0] slotPc_o, slotTarget_o;
  logic [FETCH_WIDTH-1:0][TagW-1:0] slotTag_o;

  // queue model indexed by tag.
  logic [PC_WIDTH-1:0] mPc [CtiDepth];
  logic [1:0] mType [CtiDepth];
  logic [PC_WIDTH-1:0] mResTarget [CtiDepth];
  logic mResDir [CtiDepth];
  logic [TagW-1:0] mHead, mTail;
  int mCount;

  // expected view of the bundle currently on the inputs.
  logic [FETCH_WIDTH-1:0] expValid, expCtrl;
  logic [FETCH_WIDTH-1:0][1:0] expType;
  logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0] expPc, expTarget;
  logic [FETCH_WIDTH-1:0][TagW-1:0] expTag;
  logic expMiss;
  int expFirst;

  int seed = 10805;
  int errors = 0;
  int checks = 0;
  int testErrors;
  int cycles = 0;

  fetchUnit #(.CtiDepth(CtiDepth)) DUT (.*);

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("timeout: the tests did not finish within %0d cycles", LIMIT);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  recoverOnAccept: assert property (@(posedge clk) disable iff (reset_i)
    flagRecover_o |-> fs1Valid_i && fs2Ready_o)
    else begin
      $display("flagRecover_o was raised without an accepted bundle");
      errors++;
    end

  updateAfterCommit: assert property (@(posedge clk) disable iff (reset_i)
    updateEn_o |-> $past(commitValid_i))
    else begin
      $display("updateEn_o was raised without a commit one cycle before");
      errors++;
    end

  task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp)
      else begin
        $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        errors++;
      end
  endtask

  task automatic stepDrive();
    @(posedge clk);
    #10;
  endtask

  task automatic randomBundle(input logic allHit);
    logic [31:0] rnd;
    logic [5:0] ops [6];
    ops = '{OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_JR, 6'h23};
    rnd = $random(seed);
    pc_i = {rnd[31:4], 4'h0}; // bundles are 16-byte aligned.
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      bundle_i[k] = $random(seed);
      rnd = $random(seed);
      bundle_i[k][31:26] = ops[rnd[7:0] % 6];
      btbTarget_i[k] = $random(seed);
    end
    rnd = $random(seed);
    btbHit_i = allHit ? 4'hf : rnd[3:0];
    prediction_i = rnd[7:4];
    rasTop_i = $random(seed);
  endtask

  task automatic condBundle(input logic [5:0] op1);
    randomBundle(1'b1);
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      bundle_i[k][31:26] = OP_BEQ;
    end
    bundle_i[1][31:26] = op1;
    prediction_i = 4'h0; // not taken, so every slot survives.
  endtask

  // predecode and first-redirect rules applied to the current inputs.
  task automatic predict();
    logic found;
    logic [5:0] op;
    logic [15:0] off;
    found = 1'b0;
    expFirst = 0;
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      op = bundle_i[k][31:26];
      off = bundle_i[k][15:0];
      expPc[k] = pc_i + 32'(4 * k);
      expCtrl[k] = op == OP_BEQ || op == OP_BNE || op == OP_J || op == OP_JAL || op == OP_JR;
      expType[k] = CTRL_COND;
      expTarget[k] = expPc[k] + 32'd4 + {{14{off[15]}}, off, 2'b00};
      if (op == OP_J || op == OP_JAL) begin
        expType[k] = (op == OP_J) ? CTRL_JUMP : CTRL_CALL;
        expTarget[k] = {expPc[k][31:28], bundle_i[k][25:0], 2'b00};
      end else if (op == OP_JR) begin
        expType[k] = CTRL_RETURN;
        expTarget[k] = btbTarget_i[k];
      end
      expValid[k] = !found;
      if (!found && expCtrl[k] && (prediction_i[k] || expType[k] != CTRL_COND)) begin
        found = 1'b1;
        expFirst = k;
      end
    end
    expMiss = found && !btbHit_i[expFirst];
    if (expMiss && expType[expFirst] == CTRL_RETURN) expTarget[expFirst] = rasTop_i;
  endtask

  // presents the bundle, checks redirects at acceptance and the register one cycle on.
  task automatic sendBundle();
    predict();
    fs1Valid_i = 1'b1;
    @(negedge clk);
    while (!fs2Ready_o) @(negedge clk);
    checkVal("flagRecover_o", 32'(flagRecover_o), 32'(expMiss));
    if (expMiss) begin
      checkVal("redirectTarget_o", redirectTarget_o, expTarget[expFirst]);
      checkVal("flagReturn_o", 32'(flagReturn_o), 32'(expType[expFirst] == CTRL_RETURN));
      checkVal("flagCall_o", 32'(flagCall_o), 32'(expType[expFirst] == CTRL_CALL));
      if (expType[expFirst] == CTRL_CALL) checkVal("callPc_o", callPc_o, expPc[expFirst]);
    end
    stepDrive();
    fs1Valid_i = 1'b0;
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      if (expValid[k] && expCtrl[k]) begin
        expTag[k] = mTail;
        mPc[mTail] = expPc[k];
        mType[mTail] = expType[k];
        mTail++;
        mCount++;
      end
    end
    @(negedge clk);
    checkVal("bundleValid_o", 32'(bundleValid_o), 32'd1);
    checkVal("slotValid_o", 32'(slotValid_o), 32'(expValid));
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      if (expValid[k]) begin
        checkVal($sformatf("slotPc_o[%0d]", k), slotPc_o[k], expPc[k]);
        checkVal($sformatf("slotInst_o[%0d]", k), slotInst_o[k], bundle_i[k]);
        checkVal($sformatf("slotPred_o[%0d]", k), 32'(slotPred_o[k]), 32'(prediction_i[k]));
      end
      if (expValid[k] && expCtrl[k]) begin
        checkVal($sformatf("slotTarget_o[%0d]", k), slotTarget_o[k], expTarget[k]);
        checkVal($sformatf("slotTag_o[%0d]", k), 32'(slotTag_o[k]), 32'(expTag[k]));
      end
    end
  endtask

  task automatic flushAll();
    stepDrive();
    flush_i = 1'b1;
    stepDrive();
    flush_i = 1'b0;
    mHead = mTail;
    mCount = 0;
  endtask

  task automatic endTest(input string name);
    $display("test %s finished with %0d errors", name, errors - testErrors);
    testErrors = errors;
  endtask

  initial begin
    logic [31:0] rnd;
    logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0] heldPc;
    logic [FETCH_WIDTH-1:0][INST_WIDTH-1:0] heldInst;
    reset_i = 1'b1;
    flush_i = 1'b0;
    fs1Valid_i = 1'b0;
    decodeReady_i = 1'b1;
    pc_i = '0;
    bundle_i = '0;
    btbHit_i = '0;
    btbTarget_i = '0;
    prediction_i = '0;
    rasTop_i = '0;
    resolveValid_i = 1'b0;
    resolveTag_i = '0;
    resolveTarget_i = '0;
    resolveTaken_i = 1'b0;
    recoverEx_i = 1'b0;
    commitValid_i = 1'b0;
    mHead = '0;
    mTail = '0;
    mCount = 0;
    testErrors = 0;
    repeat (8) @(posedge clk);
    #10;
    reset_i = 1'b0;

    for (int i = 0; i < N_RAND; i++) begin
      stepDrive();
      randomBundle(1'b0);
      sendBundle();
      flushAll();
    end
    endTest("truncation");

    for (int i = 0; i < N_HIT + 2; i++) begin
      stepDrive();
      randomBundle(i < N_HIT);
      if (i == N_HIT) bundle_i[0][31:26] = OP_JR;
      if (i == N_HIT + 1) bundle_i[0][31:26] = OP_JAL;
      if (i >= N_HIT) btbHit_i[0] = 1'b0;
      sendBundle();
      flushAll();
    end
    endTest("redirect");

    for (int i = 0; i < 4; i++) begin
      stepDrive();
      condBundle(OP_BEQ);
      sendBundle();
      checkVal("fs2Ready_o", 32'(fs2Ready_o), 32'(mCount <= CtiDepth - FETCH_WIDTH));
    end
    stepDrive();
    condBundle(OP_BEQ);
    fs1Valid_i = 1'b1;
    repeat (3) begin
      @(negedge clk);
      checkVal("fs2Ready_o", 32'(fs2Ready_o), 32'd0);
    end
    stepDrive();
    fs1Valid_i = 1'b0;
    flushAll();
    stepDrive();
    decodeReady_i = 1'b0;
    sendBundle(); // tags resume at the unchanged tail.
    heldPc = slotPc_o;
    heldInst = slotInst_o;
    stepDrive();
    condBundle(OP_BNE);
    fs1Valid_i = 1'b1;
    repeat (4) begin
      @(negedge clk);
      checkVal("fs2Ready_o", 32'(fs2Ready_o), 32'd0);
      checkVal("bundleValid_o", 32'(bundleValid_o), 32'd1);
      for (int k = 0; k < FETCH_WIDTH; k++) begin
        checkVal($sformatf("slotPc_o[%0d]", k), slotPc_o[k], heldPc[k]);
        checkVal($sformatf("slotInst_o[%0d]", k), slotInst_o[k], heldInst[k]);
      end
    end
    stepDrive();
    fs1Valid_i = 1'b0;
    decodeReady_i = 1'b1;
    flushAll();
    endTest("backpressure");

    stepDrive();
    condBundle(OP_BEQ);
    sendBundle();
    stepDrive();
    condBundle(OP_J); // two entries and the second is a jump.
    sendBundle();
    for (int i = 0; i < mCount; i++) begin
      stepDrive();
      rnd = $random(seed);
      resolveValid_i = 1'b1;
      resolveTag_i = mHead + TagW'(i);
      resolveTarget_i = rnd;
      resolveTaken_i = rnd[0];
      mResTarget[resolveTag_i] = rnd;
      mResDir[resolveTag_i] = rnd[0];
    end
    stepDrive();
    resolveValid_i = 1'b0;
    while (mCount > 0) begin
      commitValid_i = 1'b1;
      stepDrive();
      commitValid_i = 1'b0;
      @(negedge clk);
      checkVal("updateEn_o", 32'(updateEn_o), 32'd1);
      checkVal("updatePc_o", updatePc_o, mPc[mHead]);
      checkVal("updateCtrlType_o", 32'(updateCtrlType_o), 32'(mType[mHead]));
      checkVal("updateTarget_o", updateTarget_o, mResTarget[mHead]);
      checkVal("updateDir_o", 32'(updateDir_o), 32'(mResDir[mHead]));
      mHead++;
      mCount--;
      stepDrive();
    end
    endTest("commit");

    stepDrive();
    condBundle(OP_BEQ);
    sendBundle();
    stepDrive();
    recoverEx_i = 1'b1;
    resolveTag_i = mHead + TagW'(1);
    stepDrive();
    recoverEx_i = 1'b0;
    mTail = mHead + TagW'(2);
    mCount = 2;
    condBundle(OP_BEQ);
    decodeReady_i = 1'b0;
    sendBundle(); // first tag must follow the squashed one.
    flushAll();
    decodeReady_i = 1'b1;
    @(negedge clk);
    checkVal("bundleValid_o", 32'(bundleValid_o), 32'd0);
    checkVal("fs2Ready_o", 32'(fs2Ready_o), 32'd1);
    stepDrive();
    condBundle(OP_BNE);
    sendBundle();
    endTest("squash and flush");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire
